/* Makefile */
TOP = usiSystemTb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f all.f --top-module usiSystem
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* all.f */
+incdir+hdl
hdl/usiBusPkg.sv
hdl/blockMapPkg.sv
hdl/usiSlaveIf.sv
hdl/usiDecode.sv
hdl/gpioBlock.sv
hdl/scratchBlock.sv
hdl/usiReadMerge.sv
hdl/usiSystem.sv
dv/usiChecks.sv
dv/usiSystemTb.sv

/* dv/usiChecks.sv */
//----------------------------------------------------------
// Testbench assertions on read returns and LED outputs
//----------------------------------------------------------
`timescale 1ns/1ps

module usiChecks
	import usiBusPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	// Expectations from the testbench aligned with Ed
	input  logic       rdIssue,
	input  usiData_t   expRd,
	input  logic [1:0] expLed,
	input  logic [2:0] expRgb,
	// DUT outputs
	input  usiData_t   usiRd,
	input  logic       usiRdValid,
	input  logic [1:0] led,
	input  logic       ledR,
	input  logic       ledG,
	input  logic       ledB,
	output logic       failed
);

	logic       rstD = 1'b0;
	logic       issueQ1;
	logic       issueQ2;
	usiData_t   expRdQ1;
	usiData_t   expRdQ2;
	logic [1:0] expLedQ1;
	logic [1:0] expLedQ2;
	logic [2:0] expRgbQ1;
	logic [2:0] expRgbQ2;

	initial failed = 1'b0;

	task automatic reportMismatch(input string name, input logic [31:0] expVal,
		input logic [31:0] gotVal);
		$display("ERR time %0t signal %s expected %0h got %0h", $time, name, expVal, gotVal);
		failed = 1'b1;
	endtask

	//----------------------------------------------------------
	// Two-cycle delay of the expectations
	//----------------------------------------------------------
	always @(posedge clk)
	begin
		rstD     <= rst;
		issueQ1  <= rdIssue;
		issueQ2  <= issueQ1;
		expRdQ1  <= expRd;
		expRdQ2  <= expRdQ1;
		expLedQ1 <= expLed;
		expLedQ2 <= expLedQ1;
		expRgbQ1 <= expRgb;
		expRgbQ2 <= expRgbQ1;
	end

	// Outputs quiet through reset and just after it
	afterReset: assert property (@(posedge clk)
		rstD |-> (!usiRdValid && led == 2'b00 && {ledB, ledG, ledR} == 3'b000))
		else reportMismatch("usiRdValid/led/ledRGB", 32'h0,
			{26'h0, $sampled(usiRdValid), $sampled(ledB), $sampled(ledG),
			$sampled(ledR), $sampled(led)});

	// Valid exactly in the slot two cycles after a mapped read
	rdValidSlot: assert property (@(posedge clk) disable iff (rst)
		usiRdValid == issueQ2)
		else reportMismatch("usiRdValid", {31'h0, $sampled(issueQ2)},
			{31'h0, $sampled(usiRdValid)});

	rdDataMatch: assert property (@(posedge clk) disable iff (rst)
		issueQ2 |-> usiRd == expRdQ2)
		else reportMismatch("usiRd", $sampled(expRdQ2), $sampled(usiRd));

	// LED registers follow the shadow from the third cycle
	ledMatch: assert property (@(posedge clk) disable iff (rst)
		led == expLedQ2)
		else reportMismatch("led", {30'h0, $sampled(expLedQ2)}, {30'h0, $sampled(led)});

	rgbMatch: assert property (@(posedge clk) disable iff (rst)
		{ledB, ledG, ledR} == expRgbQ2)
		else reportMismatch("ledB/ledG/ledR", {29'h0, $sampled(expRgbQ2)},
			{29'h0, $sampled(ledB), $sampled(ledG), $sampled(ledR)});

endmodule

/* dv/usiSystemTb.sv */
//----------------------------------------------------------
// Testbench for the USI bus top with a register shadow model
//----------------------------------------------------------
`timescale 1ns/1ps
`include "usi_macros.svh"

module usiSystemTb
	import usiBusPkg::*;
	import blockMapPkg::*;
();

	logic       clk;
	logic       rst;
	logic       usiSel;
	usiAdrs_t   mcbAdrs;
	usiData_t   mcbWd;
	logic       mcbEd;
	logic       mcbWr;
	usiAdrs_t   extAdrs;
	usiData_t   extWd;
	logic       extEd;
	logic       extWr;
	usiData_t   usiRd;
	logic       usiRdValid;
	logic [1:0] led;
	logic       ledR;
	logic       ledG;
	logic       ledB;

	// Shadow model and expectations for the checker
	logic       rdIssue;
	usiData_t   expRd;
	logic [1:0] ledShadow;
	logic [2:0] rgbShadow;
	usiData_t   scratchShadow [SCRATCH_WORDS];
	logic       checkFailed;

	usiSystem uut (
		.clk        (clk),
		.rst        (rst),
		.usiSel     (usiSel),
		.mcbAdrs    (mcbAdrs),
		.mcbWd      (mcbWd),
		.mcbEd      (mcbEd),
		.mcbWr      (mcbWr),
		.extAdrs    (extAdrs),
		.extWd      (extWd),
		.extEd      (extEd),
		.extWr      (extWr),
		.usiRd      (usiRd),
		.usiRdValid (usiRdValid),
		.led        (led),
		.ledR       (ledR),
		.ledG       (ledG),
		.ledB       (ledB)
	);

	usiChecks checks (
		.clk        (clk),
		.rst        (rst),
		.rdIssue    (rdIssue),
		.expRd      (expRd),
		.expLed     (ledShadow),
		.expRgb     (rgbShadow),
		.usiRd      (usiRd),
		.usiRdValid (usiRdValid),
		.led        (led),
		.ledR       (ledR),
		.ledG       (ledG),
		.ledB       (ledB),
		.failed     (checkFailed)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge checkFailed)
	begin
		$display("Testbench failed");
		$fatal(1, "an assertion in the checker did not hold");
	end

	//----------------------------------------------------------
	// Address build and read prediction
	//----------------------------------------------------------
	function automatic usiAdrs_t makeAdrs(input logic [`BLOCK_MAP_W-1:0] blk,
		input csrAdrs_t csr);
		usiAdrs_t adrs;
		adrs = '0;
		adrs[`BLOCK_MAP_LSB +: `BLOCK_MAP_W] = blk;
		adrs[`CSR_ADRS_W-1:0] = csr;
		return adrs;
	endfunction

	// Zero-extended register, zero for unknown indices
	function automatic usiData_t predictRead(input logic [`BLOCK_MAP_W-1:0] blk,
		input csrActive_t idx);
		usiData_t word;
		word = '0;
		if (blk == GPIO_BLOCK && idx == GPIO_LED)
			word[1:0] = ledShadow;
		else if (blk == GPIO_BLOCK && idx == GPIO_RGB)
			word[2:0] = rgbShadow;
		else if (blk == SCRATCH_BLOCK && idx < 8'(SCRATCH_WORDS))
			word = scratchShadow[idx[1:0]];
		return word;
	endfunction

	//----------------------------------------------------------
	// Bus driving tasks
	//----------------------------------------------------------
	task automatic issueAccess(input logic fromExt, input logic write, input usiAdrs_t adrs,
		input usiData_t data);
		logic                    taken;
		logic                    mapped;
		logic [`BLOCK_MAP_W-1:0] blk;
		csrActive_t              idx;
		@(posedge clk);
		taken  = (fromExt == usiSel);
		blk    = adrs[`BLOCK_MAP_LSB +: `BLOCK_MAP_W];
		idx    = adrs[`CSR_ACTIVE_W-1:0];
		mapped = (blk == GPIO_BLOCK) || (blk == SCRATCH_BLOCK);
		if (fromExt)
		begin
			extAdrs <= adrs;
			extWd   <= data;
			extWr   <= write;
			extEd   <= 1'b1;
			mcbEd   <= 1'b0;
		end
		else
		begin
			mcbAdrs <= adrs;
			mcbWd   <= data;
			mcbWr   <= write;
			mcbEd   <= 1'b1;
			extEd   <= 1'b0;
		end
		rdIssue <= taken && !write && mapped;
		expRd   <= predictRead(blk, idx);
		// Shadow follows only writes that the bus accepts
		if (taken && write)
		begin
			if (blk == GPIO_BLOCK && idx == GPIO_LED)
				ledShadow <= data[1:0];
			else if (blk == GPIO_BLOCK && idx == GPIO_RGB)
				rgbShadow <= data[2:0];
			else if (blk == SCRATCH_BLOCK && idx < 8'(SCRATCH_WORDS))
				scratchShadow[idx[1:0]] <= data;
		end
	endtask

	task automatic idleBus(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			mcbEd   <= 1'b0;
			extEd   <= 1'b0;
			rdIssue <= 1'b0;
		end
	endtask

	task automatic selectMaster(input logic ext);
		@(posedge clk);
		usiSel  <= ext;
		mcbEd   <= 1'b0;
		extEd   <= 1'b0;
		rdIssue <= 1'b0;
	endtask

	task automatic waitReadReturn();
		int cycles;
		cycles = 0;
		while (usiRdValid !== 1'b1 && cycles < 6)
		begin
			@(negedge clk);
			cycles++;
		end
		if (usiRdValid !== 1'b1)
		begin
			$display("Testbench failed");
			$fatal(1, "read return did not arrive within 6 cycles");
		end
	endtask

	task automatic readAndWait(input logic fromExt, input usiAdrs_t adrs);
		issueAccess(fromExt, 1'b0, adrs, '0);
		idleBus(1);
		waitReadReturn();
	endtask

	//----------------------------------------------------------
	// Stimulus
	//----------------------------------------------------------
	initial
	begin
		logic                    fromExt;
		logic                    write;
		logic [`BLOCK_MAP_W-1:0] blk;
		csrAdrs_t                csr;
		void'($urandom(32'h228709df));
		rst        = 1'b1;
		usiSel     = 1'b0;
		mcbAdrs    = '0;
		mcbWd      = '0;
		mcbEd      = 1'b0;
		mcbWr      = 1'b0;
		extAdrs    = '0;
		extWd      = '0;
		extEd      = 1'b0;
		extWr      = 1'b0;
		rdIssue    = 1'b0;
		expRd      = '0;
		ledShadow  = '0;
		rgbShadow  = '0;
		for (int i = 0; i < SCRATCH_WORDS; i++)
			scratchShadow[i] = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		idleBus(2);

		// Controller master owns the bus
		issueAccess(1'b0, 1'b1, makeAdrs(GPIO_BLOCK, 16'h0000), 32'hffff_fffe);
		issueAccess(1'b0, 1'b1, makeAdrs(GPIO_BLOCK, 16'h0001), 32'h0000_0005);
		readAndWait(1'b0, makeAdrs(GPIO_BLOCK, 16'h0000));
		readAndWait(1'b0, makeAdrs(GPIO_BLOCK, 16'h0001));
		for (int i = 0; i < SCRATCH_WORDS; i++)
			issueAccess(1'b0, 1'b1, makeAdrs(SCRATCH_BLOCK, 16'(i)), $urandom);
		for (int i = 0; i < SCRATCH_WORDS; i++)
			readAndWait(1'b0, makeAdrs(SCRATCH_BLOCK, 16'(i)));

		// External master wins, controller pulses are dropped
		selectMaster(1'b1);
		readAndWait(1'b1, makeAdrs(SCRATCH_BLOCK, 16'h0002));
		issueAccess(1'b0, 1'b1, makeAdrs(GPIO_BLOCK, 16'h0000), 32'h0000_0001);
		issueAccess(1'b0, 1'b0, makeAdrs(SCRATCH_BLOCK, 16'h0001), '0);
		idleBus(3);
		readAndWait(1'b1, makeAdrs(GPIO_BLOCK, 16'h0000));

		// Aliased CSR bits, scratch index out of range, unmapped blocks
		issueAccess(1'b1, 1'b1, makeAdrs(SCRATCH_BLOCK, 16'h0100), 32'hcafe_0001);
		readAndWait(1'b1, makeAdrs(SCRATCH_BLOCK, 16'h0000));
		readAndWait(1'b1, makeAdrs(GPIO_BLOCK, 16'h0301));
		issueAccess(1'b1, 1'b1, makeAdrs(SCRATCH_BLOCK, 16'h0007), 32'hdead_0007);
		readAndWait(1'b1, makeAdrs(SCRATCH_BLOCK, 16'h0007));
		readAndWait(1'b1, makeAdrs(GPIO_BLOCK, 16'h0002));
		issueAccess(1'b1, 1'b1, makeAdrs(4'd3, 16'h0000), 32'h0000_0003);
		issueAccess(1'b1, 1'b0, makeAdrs(4'd3, 16'h0000), '0);
		issueAccess(1'b1, 1'b0, makeAdrs(4'd0, 16'h0001), '0);
		idleBus(3);
		readAndWait(1'b1, makeAdrs(SCRATCH_BLOCK, 16'h0003));

		// Back-to-back random traffic, about a quarter on the idle master
		for (int n = 0; n < 300; n++)
		begin
			if ($urandom_range(15, 0) == 0)
				selectMaster(1'($urandom_range(1, 0)));
			fromExt = ($urandom_range(3, 0) == 0) ? !usiSel : usiSel;
			write   = 1'($urandom_range(1, 0));
			blk     = 4'($urandom_range(3, 0));
			csr     = {8'($urandom), 8'($urandom_range(5, 0))};
			issueAccess(fromExt, write, makeAdrs(blk, csr), $urandom);
		end
		idleBus(4);

		if (checkFailed)
		begin
			$display("Testbench failed");
			$fatal(1, "a check failed during the run");
		end
		else
		begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

/* hdl/blockMapPkg.sv */
//----------------------------------------------------------
// Block map codes and per-block register indices
//----------------------------------------------------------
`include "usi_macros.svh"

package blockMapPkg;
	import usiBusPkg::*;

	// Block codes, other values are unmapped
	typedef enum logic [`BLOCK_MAP_W-1:0] {
		GPIO_BLOCK    = 1,
		SCRATCH_BLOCK = 2
	} blockMap_t;

	// GPIO register indices
	typedef enum csrActive_t {
		GPIO_LED = 0,
		GPIO_RGB = 1
	} gpioReg_t;

	// Scratch bank size and its index
	localparam int SCRATCH_WORDS = 4;
	typedef logic [$clog2(SCRATCH_WORDS)-1:0] scratchIdx_t;

endpackage

/* hdl/gpioBlock.sv */
//----------------------------------------------------------
// LED and RGB LED control registers with read-back
//----------------------------------------------------------
`timescale 1ns/1ps

module gpioBlock
	import usiBusPkg::*;
	import blockMapPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	usiSlaveIf.block   bus,
	output logic [1:0] led,
	output logic       ledR,
	output logic       ledG,
	output logic       ledB
);

	logic [1:0] ledReg;
	logic [2:0] rgbReg;
	usiData_t   rdWord;

	//----------------------------------------------------------
	// Register writes
	//----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ledReg <= '0;
			rgbReg <= '0;
		end
		else if (bus.wrStrobe)
		begin
			case (gpioReg_t'(bus.csrAdrs))
				GPIO_LED: ledReg <= bus.wrData[1:0];
				GPIO_RGB: rgbReg <= bus.wrData[2:0];
				default: ;
			endcase
		end
	end

	//----------------------------------------------------------
	// Read-back
	//----------------------------------------------------------
	// Zero-extended, unknown index reads zero
	always_comb
	begin
		rdWord = '0;
		case (gpioReg_t'(bus.csrAdrs))
			GPIO_LED: rdWord[1:0] = ledReg;
			GPIO_RGB: rdWord[2:0] = rgbReg;
			default: ;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (bus.rdStrobe)
			bus.rdData <= rdWord;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			bus.rdValid <= 1'b0;
		else
			bus.rdValid <= bus.rdStrobe;
	end

	// R on bit 0, then G, then B
	assign led  = ledReg;
	assign ledR = rgbReg[0];
	assign ledG = rgbReg[1];
	assign ledB = rgbReg[2];

	noWrRd: assert property (@(posedge clk) disable iff (rst)
		!(bus.wrStrobe && bus.rdStrobe));

endmodule

/* hdl/scratchBlock.sv */
//----------------------------------------------------------
// Four-word read/write scratch register bank
//----------------------------------------------------------
`timescale 1ns/1ps

module scratchBlock
	import usiBusPkg::*;
	import blockMapPkg::*;
(
	input  logic     clk,
	input  logic     rst,
	usiSlaveIf.block bus
);

	usiData_t    regs [SCRATCH_WORDS];
	scratchIdx_t idx;
	logic        inRange;

	// Indices above the bank are ignored
	assign idx     = bus.csrAdrs[$bits(scratchIdx_t)-1:0];
	assign inRange = int'(bus.csrAdrs) < SCRATCH_WORDS;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < SCRATCH_WORDS; i++)
				regs[i] <= '0;
		end
		else if (bus.wrStrobe && inRange)
		begin
			regs[idx] <= bus.wrData;
		end
	end

	//----------------------------------------------------------
	// Read return
	//----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (bus.rdStrobe)
			bus.rdData <= inRange ? regs[idx] : '0;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			bus.rdValid <= 1'b0;
		else
			bus.rdValid <= bus.rdStrobe;
	end

	// Decoder must hold strobes low through reset
	quietInReset: assert property (@(posedge clk)
		rst |=> !(bus.wrStrobe || bus.rdStrobe));

endmodule

/* hdl/usiBusPkg.sv */
//----------------------------------------------------------
// USI bus word, address and CSR field types
//----------------------------------------------------------
`include "usi_macros.svh"

package usiBusPkg;

	//----------------------------------------------------------
	// Bus payload
	//----------------------------------------------------------
	typedef logic [`USI_DATA_W-1:0] usiData_t;
	typedef logic [`USI_ADRS_W-1:0] usiAdrs_t;

	//----------------------------------------------------------
	// Address fields inside a block
	//----------------------------------------------------------
	// Full CSR address, bits 15..0
	typedef logic [`CSR_ADRS_W-1:0] csrAdrs_t;

	// Low CSR bits, upper bits alias
	typedef logic [`CSR_ACTIVE_W-1:0] csrActive_t;

endpackage

/* hdl/usiDecode.sv */
//----------------------------------------------------------
// Master select, address split and per-block strobes
//----------------------------------------------------------
`timescale 1ns/1ps
`include "usi_macros.svh"

module usiDecode
	import usiBusPkg::*;
	import blockMapPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      usiSel,
	// On-chip controller master
	input  usiAdrs_t  mcbAdrs,
	input  usiData_t  mcbWd,
	input  logic      mcbEd,
	input  logic      mcbWr,
	// External processor master
	input  usiAdrs_t  extAdrs,
	input  usiData_t  extWd,
	input  logic      extEd,
	input  logic      extWr,
	// Slaves
	usiSlaveIf.decoder gpioBus,
	usiSlaveIf.decoder scratchBus
);

	usiAdrs_t   selAdrs;
	usiData_t   selWd;
	logic       selEd;
	logic       selWr;
	csrAdrs_t   csrField;
	csrActive_t csrIdx;
	blockMap_t  blockField;
	logic       hitGpio;
	logic       hitScratch;

	usiData_t   wrDataQ;
	csrActive_t csrIdxQ;

	//----------------------------------------------------------
	// Master select and address split
	//----------------------------------------------------------
	// External port wins while usiSel is high
	assign selAdrs = usiSel ? extAdrs : mcbAdrs;
	assign selWd   = usiSel ? extWd   : mcbWd;
	assign selEd   = usiSel ? extEd   : mcbEd;
	assign selWr   = usiSel ? extWr   : mcbWr;

	assign blockField = blockMap_t'(selAdrs[`BLOCK_MAP_LSB +: `BLOCK_MAP_W]);
	assign csrField   = selAdrs[`CSR_ADRS_W-1:0];
	assign csrIdx     = csrField[`CSR_ACTIVE_W-1:0];

	// Unmapped codes hit nothing
	assign hitGpio    = selEd && (blockField == GPIO_BLOCK);
	assign hitScratch = selEd && (blockField == SCRATCH_BLOCK);

	//----------------------------------------------------------
	// Register stage
	//----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		wrDataQ <= selWd;
		csrIdxQ <= csrIdx;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			gpioBus.wrStrobe    <= 1'b0;
			gpioBus.rdStrobe    <= 1'b0;
			scratchBus.wrStrobe <= 1'b0;
			scratchBus.rdStrobe <= 1'b0;
		end
		else
		begin
			gpioBus.wrStrobe    <= hitGpio && selWr;
			gpioBus.rdStrobe    <= hitGpio && !selWr;
			scratchBus.wrStrobe <= hitScratch && selWr;
			scratchBus.rdStrobe <= hitScratch && !selWr;
		end
	end

	// Payload shared by both slaves
	assign gpioBus.wrData    = wrDataQ;
	assign gpioBus.csrAdrs   = csrIdxQ;
	assign scratchBus.wrData  = wrDataQ;
	assign scratchBus.csrAdrs = csrIdxQ;

	// Only one slave sees one strobe per access
	oneStrobe: assert property (@(posedge clk) disable iff (rst)
		$onehot0({gpioBus.wrStrobe, gpioBus.rdStrobe,
			scratchBus.wrStrobe, scratchBus.rdStrobe}));

endmodule

/* hdl/usiReadMerge.sv */
//----------------------------------------------------------
// Merge of slave read returns into one master return
//----------------------------------------------------------
`timescale 1ns/1ps

module usiReadMerge
	import usiBusPkg::*;
(
	usiSlaveIf.merge gpioBus,
	usiSlaveIf.merge scratchBus,
	output usiData_t usiRd,
	output logic     usiRdValid
);

	usiData_t gpioMask;
	usiData_t scratchMask;

	// Data of a slave counts only while it is valid
	assign gpioMask    = {$bits(usiData_t){gpioBus.rdValid}};
	assign scratchMask = {$bits(usiData_t){scratchBus.rdValid}};

	assign usiRd      = (gpioBus.rdData & gpioMask) | (scratchBus.rdData & scratchMask);
	assign usiRdValid = gpioBus.rdValid | scratchBus.rdValid;

	// Reads are issued one per cycle, so returns never collide
	always_comb
	begin
		oneValid: assert final (!(gpioBus.rdValid === 1'b1 &&
			scratchBus.rdValid === 1'b1));
	end

endmodule

/* hdl/usiSlaveIf.sv */
//----------------------------------------------------------
// One decoded USI access to a slave and its read return
//----------------------------------------------------------
`timescale 1ns/1ps

interface usiSlaveIf import usiBusPkg::*; ();

	// Decoder to slave, registered
	usiData_t   wrData;
	csrActive_t csrAdrs;
	logic       wrStrobe;
	logic       rdStrobe;

	// Slave to merge, registered in the slave
	usiData_t   rdData;
	logic       rdValid;

	modport decoder (
		output wrData, csrAdrs, wrStrobe, rdStrobe
	);

	modport block (
		input  wrData, csrAdrs, wrStrobe, rdStrobe,
		output rdData, rdValid
	);

	modport merge (
		input  rdData, rdValid
	);

endinterface

/* hdl/usiSystem.sv */
//----------------------------------------------------------
// USI register bus top with two masters and two slaves
//----------------------------------------------------------
`timescale 1ns/1ps

module usiSystem
	import usiBusPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       usiSel,
	// On-chip controller master
	input  usiAdrs_t   mcbAdrs,
	input  usiData_t   mcbWd,
	input  logic       mcbEd,
	input  logic       mcbWr,
	// External processor master
	input  usiAdrs_t   extAdrs,
	input  usiData_t   extWd,
	input  logic       extEd,
	input  logic       extWr,
	// Read return to both masters
	output usiData_t   usiRd,
	output logic       usiRdValid,
	// Board LEDs
	output logic [1:0] led,
	output logic       ledR,
	output logic       ledG,
	output logic       ledB
);

	usiSlaveIf gpioBus ();
	usiSlaveIf scratchBus ();

	//----------------------------------------------------------
	// Decode
	//----------------------------------------------------------
	usiDecode decode (
		.clk        (clk),
		.rst        (rst),
		.usiSel     (usiSel),
		.mcbAdrs    (mcbAdrs),
		.mcbWd      (mcbWd),
		.mcbEd      (mcbEd),
		.mcbWr      (mcbWr),
		.extAdrs    (extAdrs),
		.extWd      (extWd),
		.extEd      (extEd),
		.extWr      (extWr),
		.gpioBus    (gpioBus.decoder),
		.scratchBus (scratchBus.decoder)
	);

	//----------------------------------------------------------
	// Slaves and read merge
	//----------------------------------------------------------
	gpioBlock gpio (
		.clk  (clk),
		.rst  (rst),
		.bus  (gpioBus.block),
		.led  (led),
		.ledR (ledR),
		.ledG (ledG),
		.ledB (ledB)
	);

	scratchBlock scratch (
		.clk (clk),
		.rst (rst),
		.bus (scratchBus.block)
	);

	usiReadMerge merge (
		.gpioBus    (gpioBus.merge),
		.scratchBus (scratchBus.merge),
		.usiRd      (usiRd),
		.usiRdValid (usiRdValid)
	);

endmodule

/* hdl/usi_macros.svh */
//----------------------------------------------------------
// USI bus widths and block map field position
//----------------------------------------------------------
`ifndef USI_MACROS_SVH
`define USI_MACROS_SVH

// Bus word and address
`define USI_DATA_W 32
`define USI_ADRS_W 32

// Block map field, bits 19..16 of the bus address
`define BLOCK_MAP_W 4
`define BLOCK_MAP_LSB 16

// CSR field and the part a block actually decodes
`define CSR_ADRS_W 16
`define CSR_ACTIVE_W 8

`endif
